//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;     // Index zero is x0 and never hazards.
  typedef word_t [NUM_REGS-1:0] reg_file_t;

  typedef enum logic [5:0] {
    op_lui, op_auipc,
    op_jal, op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lb, op_lh, op_lw, op_lbu, op_lhu,
    op_sb, op_sh, op_sw,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
    op_slli, op_srli, op_srai,
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    op_fence, op_fence_i, op_ecall,
    op_csrrw, op_csrrs, op_csrrc,
    op_csrrwi, op_csrrsi, op_csrrci,
    op_ebreak,
    op_mul, op_mulh, op_mulhsu, op_mulhu,
    op_div, op_divu, op_rem, op_remu,
    op_trap                                    // Decode could not make sense of the word.
  } op_e;

endpackage

//--- hdl/dpu_pkg.sv
package dpu_pkg;

  localparam int NUM_UNITS   = 6;
  localparam int NUM_TRACKED = 7;
  localparam int EXU_IDX     = NUM_TRACKED - 1; // Last tracked entry is the execute stage.

  // Encoding doubles as the bit position in unit_vld_t.
  typedef enum logic [2:0] {
    alu,
    mpu,
    dvu,
    lsu,
    csu,
    bru,
    none
  } unit_e;

  typedef logic [NUM_UNITS-1:0] unit_vld_t;

  typedef struct packed {
    logic                 vld;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
  } reg_use_t;

  typedef reg_use_t [NUM_TRACKED-1:0] reg_use_arr_t;

  typedef struct packed {
    rv_isa_pkg::op_e      op;
    rv_isa_pkg::word_t    inst;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
    logic                 br_taken;
    rv_isa_pkg::word_t    br_pred_pc_next;
  } dispatch_inst_t;

  typedef struct packed {
    logic freeze;
    logic br_miss;
    logic trap;
  } exu_status_t;

  typedef struct packed {
    rv_isa_pkg::word_t pc_imm20;               // JAL target.
    rv_isa_pkg::word_t pc_imm12;               // Conditional branch target.
    rv_isa_pkg::word_t rs1_imm11;              // JALR target.
  } branch_targets_t;

endpackage

//--- hdl/dispatch_reg.sv
`timescale 1ns/1ns

module dispatch_reg (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    idu_vld,
  input  dpu_pkg::dispatch_inst_t idu_inst,
  input  logic                    freeze,
  input  logic                    flush,
  output logic                    dpu_vld,
  output dpu_pkg::dispatch_inst_t dpu_inst
);

  logic hold;
  logic capture;

  assign hold    = dpu_vld & freeze;              // Slot is occupied and cannot move on.
  assign capture = idu_vld & ~hold;

  // Flush beats capture, so a new word arriving with a flush is dropped.
  always_ff @(posedge clk)
  begin
    if (rst)
      dpu_vld <= 1'b0;
    else if (flush)
      dpu_vld <= 1'b0;
    else
      dpu_vld <= capture | hold;
  end

  always_ff @(posedge clk)
  begin
    if (capture)
      dpu_inst <= idu_inst;
  end

endmodule

//--- hdl/pipe_control.sv
`timescale 1ns/1ns

module pipe_control (
  input  logic                    dpu_vld,
  input  dpu_pkg::dispatch_inst_t dpu_inst,
  input  dpu_pkg::reg_use_arr_t   reg_use,
  input  dpu_pkg::exu_status_t    exu,
  output logic                    freeze,
  output logic                    flush
);

  logic [dpu_pkg::NUM_TRACKED-1:0] entry_hit;
  logic                            hazard;
  logic                            exu_vld;

  // True when a nonzero index appears anywhere in one tracked entry.
  function automatic logic idx_hit(
    input rv_isa_pkg::reg_idx_t idx,
    input dpu_pkg::reg_use_t    ent
  );
    return (idx != '0) && ((idx == ent.rs1) || (idx == ent.rs2) || (idx == ent.rd));
  endfunction

  always_comb
  begin
    for (int i = 0; i < dpu_pkg::NUM_TRACKED; i++)
    begin
      entry_hit[i] = reg_use[i].vld &&
                     (idx_hit(dpu_inst.rs1, reg_use[i]) ||
                      idx_hit(dpu_inst.rs2, reg_use[i]) ||
                      idx_hit(dpu_inst.rd,  reg_use[i]));
    end
  end

  assign hazard  = |entry_hit;
  assign exu_vld = reg_use[dpu_pkg::EXU_IDX].vld;

  assign freeze = (dpu_vld & hazard) | (exu_vld & exu.freeze);
  assign flush  = exu_vld & (exu.br_miss | exu.trap);  // Wrong path or trap kills the slot.

endmodule

//--- hdl/operand_path.sv
`timescale 1ns/1ns

module operand_path (
  input  dpu_pkg::dispatch_inst_t  dpu_inst,
  input  rv_isa_pkg::reg_file_t    regs,
  output rv_isa_pkg::word_t        rs1_data,
  output rv_isa_pkg::word_t        rs2_data,
  output dpu_pkg::branch_targets_t targets
);

  rv_isa_pkg::word_t imm20_ext;
  rv_isa_pkg::word_t imm12_ext;
  rv_isa_pkg::word_t imm11_ext;
  rv_isa_pkg::word_t rs1_sum;

  assign rs1_data = regs[dpu_inst.rs1];
  assign rs2_data = regs[dpu_inst.rs2];

  assign imm20_ext = {{(rv_isa_pkg::XLEN-21){dpu_inst.imm[20]}}, dpu_inst.imm[20:0]};
  assign imm12_ext = {{(rv_isa_pkg::XLEN-13){dpu_inst.imm[12]}}, dpu_inst.imm[12:0]};
  assign imm11_ext = {{(rv_isa_pkg::XLEN-12){dpu_inst.imm[11]}}, dpu_inst.imm[11:0]};

  assign rs1_sum = rs1_data + imm11_ext;

  assign targets.pc_imm20  = dpu_inst.pc + imm20_ext;
  assign targets.pc_imm12  = dpu_inst.pc + imm12_ext;
  assign targets.rs1_imm11 = {rs1_sum[rv_isa_pkg::XLEN-1:1], 1'b0};  // JALR drops bit 0.

endmodule

//--- hdl/unit_steer.sv
`timescale 1ns/1ns

module unit_steer (
  input  logic               dpu_vld,
  input  rv_isa_pkg::op_e    op,
  input  logic               freeze,
  input  logic               flush,
  output dpu_pkg::unit_vld_t unit_vld
);

  dpu_pkg::unit_e unit;
  logic           go;

  always_comb
  begin
    case (op)
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc,
      rv_isa_pkg::op_addi, rv_isa_pkg::op_slti, rv_isa_pkg::op_sltiu,
      rv_isa_pkg::op_xori, rv_isa_pkg::op_ori, rv_isa_pkg::op_andi,
      rv_isa_pkg::op_slli, rv_isa_pkg::op_srli, rv_isa_pkg::op_srai,
      rv_isa_pkg::op_add, rv_isa_pkg::op_sub, rv_isa_pkg::op_sll,
      rv_isa_pkg::op_slt, rv_isa_pkg::op_sltu, rv_isa_pkg::op_xor,
      rv_isa_pkg::op_srl, rv_isa_pkg::op_sra, rv_isa_pkg::op_or, rv_isa_pkg::op_and,
      rv_isa_pkg::op_fence, rv_isa_pkg::op_fence_i,
      rv_isa_pkg::op_ecall, rv_isa_pkg::op_trap:
        unit = dpu_pkg::alu;                       // ALU also retires fences and traps.
      rv_isa_pkg::op_mul, rv_isa_pkg::op_mulh,
      rv_isa_pkg::op_mulhsu, rv_isa_pkg::op_mulhu:
        unit = dpu_pkg::mpu;
      rv_isa_pkg::op_div, rv_isa_pkg::op_divu,
      rv_isa_pkg::op_rem, rv_isa_pkg::op_remu:
        unit = dpu_pkg::dvu;
      rv_isa_pkg::op_lb, rv_isa_pkg::op_lh, rv_isa_pkg::op_lw,
      rv_isa_pkg::op_lbu, rv_isa_pkg::op_lhu,
      rv_isa_pkg::op_sb, rv_isa_pkg::op_sh, rv_isa_pkg::op_sw:
        unit = dpu_pkg::lsu;
      rv_isa_pkg::op_csrrw, rv_isa_pkg::op_csrrs, rv_isa_pkg::op_csrrc,
      rv_isa_pkg::op_csrrwi, rv_isa_pkg::op_csrrsi, rv_isa_pkg::op_csrrci:
        unit = dpu_pkg::csu;
      rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr,
      rv_isa_pkg::op_beq, rv_isa_pkg::op_bne, rv_isa_pkg::op_blt,
      rv_isa_pkg::op_bge, rv_isa_pkg::op_bltu, rv_isa_pkg::op_bgeu:
        unit = dpu_pkg::bru;
      default:
        unit = dpu_pkg::none;                      // EBREAK is accepted but goes nowhere.
    endcase
  end

  assign go = dpu_vld & ~freeze & ~flush;

  always_comb
  begin
    unit_vld = '0;
    if (go && (unit != dpu_pkg::none))
      unit_vld[unit] = 1'b1;
  end

endmodule

//--- hdl/riscv_dpu.sv
`timescale 1ns/1ns

module riscv_dpu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     idu_vld,
  input  dpu_pkg::dispatch_inst_t  idu_inst,
  input  rv_isa_pkg::reg_file_t    regs,
  input  dpu_pkg::reg_use_arr_t    reg_use,
  input  dpu_pkg::exu_status_t     exu,
  output logic                     freeze,
  output logic                     dpu_vld,
  output dpu_pkg::dispatch_inst_t  dpu_inst,
  output dpu_pkg::unit_vld_t       unit_vld,
  output rv_isa_pkg::word_t        rs1_data,
  output rv_isa_pkg::word_t        rs2_data,
  output dpu_pkg::branch_targets_t targets
);

  logic flush;

  dispatch_reg u_dispatch_reg (
    .clk      (clk),
    .rst      (rst),
    .idu_vld  (idu_vld),
    .idu_inst (idu_inst),
    .freeze   (freeze),
    .flush    (flush),
    .dpu_vld  (dpu_vld),
    .dpu_inst (dpu_inst)
  );

  pipe_control u_pipe_control (
    .dpu_vld  (dpu_vld),
    .dpu_inst (dpu_inst),
    .reg_use  (reg_use),
    .exu      (exu),
    .freeze   (freeze),
    .flush    (flush)
  );

  operand_path u_operand_path (
    .dpu_inst (dpu_inst),
    .regs     (regs),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .targets  (targets)
  );

  unit_steer u_unit_steer (
    .dpu_vld  (dpu_vld),
    .op       (dpu_inst.op),
    .freeze   (freeze),
    .flush    (flush),
    .unit_vld (unit_vld)
  );

endmodule

//--- include/tb_lfsr.svh
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// 32-bit Galois LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// Collects nbits fresh bits with one LFSR step per bit.
function automatic logic [31:0] lfsr_rand(ref logic [31:0] state, input int unsigned nbits);
  logic [31:0] val;
  val = '0;
  for (int unsigned i = 0; i < nbits; i++)
  begin
    state = lfsr_step(state);
    val   = {val[30:0], state[0]};
  end
  return val;
endfunction

// Sign-extends value from bit msb upward.
function automatic logic [31:0] sext_from(input logic [31:0] value, input int unsigned msb);
  logic [31:0] mask;
  mask = 32'hFFFF_FFFF << msb;
  return value[msb] ? (value | mask) : (value & ~mask);
endfunction

`endif

//--- sim/tb_riscv_dpu.sv
`timescale 1ns/1ns

module tb_riscv_dpu;

  localparam int WAIT_LIMIT = 20;
  localparam int NUM_STEER  = 64;
  localparam int NUM_OPER   = 16;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     idu_vld;
  dpu_pkg::dispatch_inst_t  idu_inst;
  rv_isa_pkg::reg_file_t    regs;
  dpu_pkg::reg_use_arr_t    reg_use;
  dpu_pkg::exu_status_t     exu;
  logic                     freeze;
  logic                     dpu_vld;
  dpu_pkg::dispatch_inst_t  dpu_inst;
  dpu_pkg::unit_vld_t       unit_vld;
  rv_isa_pkg::word_t        rs1_data;
  rv_isa_pkg::word_t        rs2_data;
  dpu_pkg::branch_targets_t targets;

  logic [31:0] seed   = 32'd90685;
  int          checks = 0;
  int          errors = 0;

  `include "tb_lfsr.svh"

  riscv_dpu UUT (
    .clk      (clk),
    .rst      (rst),
    .idu_vld  (idu_vld),
    .idu_inst (idu_inst),
    .regs     (regs),
    .reg_use  (reg_use),
    .exu      (exu),
    .freeze   (freeze),
    .dpu_vld  (dpu_vld),
    .dpu_inst (dpu_inst),
    .unit_vld (unit_vld),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .targets  (targets)
  );

  always #10 clk = ~clk;

  // Unit table taken from the op groups of the dispatch rules.
  function automatic dpu_pkg::unit_e expected_unit(input rv_isa_pkg::op_e op);
    if (op inside {[rv_isa_pkg::op_jal:rv_isa_pkg::op_bgeu]}) return dpu_pkg::bru;
    if (op inside {[rv_isa_pkg::op_lb:rv_isa_pkg::op_sw]}) return dpu_pkg::lsu;
    if (op inside {[rv_isa_pkg::op_csrrw:rv_isa_pkg::op_csrrci]}) return dpu_pkg::csu;
    if (op inside {[rv_isa_pkg::op_mul:rv_isa_pkg::op_mulhu]}) return dpu_pkg::mpu;
    if (op inside {[rv_isa_pkg::op_div:rv_isa_pkg::op_remu]}) return dpu_pkg::dvu;
    if (op == rv_isa_pkg::op_ebreak) return dpu_pkg::none;
    return dpu_pkg::alu;
  endfunction

  function automatic dpu_pkg::unit_vld_t expected_strobes(input rv_isa_pkg::op_e op);
    dpu_pkg::unit_e u;
    u = expected_unit(op);
    return (u == dpu_pkg::none) ? dpu_pkg::unit_vld_t'(0) : (dpu_pkg::unit_vld_t'(1) << u);
  endfunction

  function automatic dpu_pkg::dispatch_inst_t random_inst();
    dpu_pkg::dispatch_inst_t inst;
    logic [31:0]             r;
    logic [5:0]              code;
    r         = lfsr_rand(seed, 6);
    code      = 6'(r % 32'd56);                   // 56 ops in the enum.
    inst.op   = rv_isa_pkg::op_e'(code);
    inst.inst = lfsr_rand(seed, 32);
    inst.pc   = lfsr_rand(seed, 32);
    inst.imm  = lfsr_rand(seed, 32);
    r         = lfsr_rand(seed, 15);
    inst.rs1  = r[14:10];
    inst.rs2  = r[9:5];
    inst.rd   = r[4:0];
    r         = lfsr_rand(seed, 1);
    inst.br_taken        = r[0];
    inst.br_pred_pc_next = lfsr_rand(seed, 32);
    return inst;
  endfunction

  function automatic rv_isa_pkg::reg_idx_t nonzero_idx();
    logic [31:0] r;
    r = lfsr_rand(seed, 5);
    return (r[4:0] == 5'd0) ? 5'd31 : r[4:0];
  endfunction

  task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Returns at the falling edge where dpu_vld has reached the level.
  task automatic wait_dpu_vld(input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while ((dpu_vld !== level) && (n < WAIT_LIMIT))
    begin
      @(negedge clk);
      n++;
    end
    if (dpu_vld !== level)
    begin
      errors++;
      $display("Timed out waiting for dpu_vld to become %0d during %s", level, what);
    end
  endtask

  task automatic send_inst(input dpu_pkg::dispatch_inst_t inst);
    @(posedge clk);
    idu_vld  <= 1'b1;
    idu_inst <= inst;
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%-16s done, %0d error(s)", name, errors - err0);
  endtask

  task automatic reset_idle();
    int err0;
    err0 = errors;
    for (int i = 0; i < 3; i++)
      @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_eq("dpu_vld", 256'(dpu_vld), 256'(0));
    check_eq("freeze", 256'(freeze), 256'(0));
    check_eq("unit_vld", 256'(unit_vld), 256'(0));
    report_test("reset", err0);
  endtask

  task automatic steering_sweep();
    dpu_pkg::dispatch_inst_t inst;
    int                      err0;
    err0 = errors;
    for (int n = 0; n <= NUM_STEER; n++)
    begin
      inst = random_inst();
      if (n == NUM_STEER)
        inst.op = rv_isa_pkg::op_ebreak;          // The no-unit case is always reached.
      send_inst(inst);
      @(posedge clk);
      idu_vld <= 1'b0;
      @(negedge clk);
      check_eq("dpu_vld", 256'(dpu_vld), 256'(1));
      check_eq("dpu_inst", 256'(dpu_inst), 256'(inst));
      check_eq("unit_vld", 256'(unit_vld), 256'(expected_strobes(inst.op)));
      @(negedge clk);
      check_eq("dpu_vld", 256'(dpu_vld), 256'(0));
      check_eq("unit_vld", 256'(unit_vld), 256'(0));
    end
    report_test("steering", err0);
  endtask

  task automatic operand_targets();
    rv_isa_pkg::reg_file_t    rf;
    dpu_pkg::dispatch_inst_t  inst;
    dpu_pkg::branch_targets_t exp_t;
    int                       err0;
    err0 = errors;
    for (int n = 0; n < NUM_OPER; n++)
    begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++)
        rf = {rf[rv_isa_pkg::NUM_REGS-2:0], lfsr_rand(seed, 32)};
      inst            = random_inst();
      exp_t.pc_imm20  = inst.pc + sext_from(inst.imm, 20);
      exp_t.pc_imm12  = inst.pc + sext_from(inst.imm, 12);
      exp_t.rs1_imm11 = (rf[inst.rs1] + sext_from(inst.imm, 11)) & ~32'd1;
      send_inst(inst);
      regs <= rf;
      @(posedge clk);
      idu_vld <= 1'b0;
      wait_dpu_vld(1'b1, "operands");
      check_eq("rs1_data", 256'(rs1_data), 256'(rf[inst.rs1]));
      check_eq("rs2_data", 256'(rs2_data), 256'(rf[inst.rs2]));
      check_eq("targets", 256'(targets), 256'(exp_t));
      wait_dpu_vld(1'b0, "operands drain");
    end
    report_test("operands", err0);
  endtask

  task automatic hazard_hold();
    dpu_pkg::dispatch_inst_t inst;
    dpu_pkg::dispatch_inst_t other;
    dpu_pkg::reg_use_t       ent;
    rv_isa_pkg::reg_idx_t    idx;
    logic [31:0]             r;
    logic [2:0]              k;
    int                      err0;
    err0 = errors;
    for (int j = 0; j < 3; j++)
    begin
      inst     = random_inst();
      inst.rs1 = nonzero_idx();
      inst.rs2 = nonzero_idx();
      inst.rd  = nonzero_idx();
      other    = random_inst();
      r        = lfsr_rand(seed, 3);
      k        = 3'(r % 32'd7);                   // Any unit or the execute stage.
      r        = lfsr_rand(seed, 2);
      idx      = (r[1:0] == 2'd0) ? inst.rs1 : ((r[1:0] == 2'd1) ? inst.rs2 : inst.rd);
      ent      = '0;
      ent.vld  = 1'b1;
      if (j == 0)
        ent.rs1 = idx;
      else if (j == 1)
        ent.rs2 = idx;
      else
        ent.rd = idx;
      send_inst(inst);
      reg_use[k] <= ent;
      @(posedge clk);
      idu_inst <= other;                          // A new word waits while frozen.
      wait_dpu_vld(1'b1, "hazard capture");
      for (int c = 0; c < 3; c++)
      begin
        check_eq("freeze", 256'(freeze), 256'(1));
        check_eq("unit_vld", 256'(unit_vld), 256'(0));
        check_eq("dpu_vld", 256'(dpu_vld), 256'(1));
        check_eq("dpu_inst", 256'(dpu_inst), 256'(inst));
        @(negedge clk);
      end
      @(posedge clk);
      reg_use[k] <= '0;
      @(negedge clk);
      check_eq("freeze", 256'(freeze), 256'(0));
      check_eq("unit_vld", 256'(unit_vld), 256'(expected_strobes(inst.op)));
      check_eq("dpu_inst", 256'(dpu_inst), 256'(inst));
      @(posedge clk);
      idu_vld <= 1'b0;
      wait_dpu_vld(1'b0, "hazard drain");
    end
    inst     = random_inst();
    inst.rs1 = '0;
    inst.rs2 = '0;
    inst.rd  = '0;
    ent      = '0;
    ent.vld  = 1'b1;
    send_inst(inst);
    reg_use[0] <= ent;
    @(posedge clk);
    idu_vld <= 1'b0;
    wait_dpu_vld(1'b1, "x0 capture");
    check_eq("freeze", 256'(freeze), 256'(0));
    check_eq("unit_vld", 256'(unit_vld), 256'(expected_strobes(inst.op)));
    @(posedge clk);
    reg_use <= '0;
    wait_dpu_vld(1'b0, "x0 drain");
    report_test("hazard hold", err0);
  endtask

  task automatic execute_freeze();
    dpu_pkg::dispatch_inst_t inst;
    dpu_pkg::reg_use_t       ent;
    dpu_pkg::exu_status_t    st;
    int                      err0;
    err0 = errors;
    for (int n = 0; n < 4; n++)
    begin
      inst      = random_inst();
      ent       = '0;
      ent.vld   = 1'b1;
      st        = '0;
      st.freeze = 1'b1;
      send_inst(inst);
      @(posedge clk);
      idu_vld                   <= 1'b0;
      reg_use[dpu_pkg::EXU_IDX] <= ent;
      exu                       <= st;
      wait_dpu_vld(1'b1, "execute freeze");
      for (int c = 0; c < 3; c++)
      begin
        check_eq("freeze", 256'(freeze), 256'(1));
        check_eq("unit_vld", 256'(unit_vld), 256'(0));
        check_eq("dpu_inst", 256'(dpu_inst), 256'(inst));
        @(negedge clk);
      end
      @(posedge clk);
      exu <= '0;
      @(negedge clk);
      check_eq("freeze", 256'(freeze), 256'(0));
      check_eq("unit_vld", 256'(unit_vld), 256'(expected_strobes(inst.op)));
      @(posedge clk);
      reg_use <= '0;
      wait_dpu_vld(1'b0, "execute freeze drain");
    end
    report_test("execute freeze", err0);
  endtask

  task automatic flush_slot(input logic use_trap, input string name);
    dpu_pkg::dispatch_inst_t inst;
    dpu_pkg::reg_use_t       ent;
    dpu_pkg::exu_status_t    st;
    int                      err0;
    err0       = errors;
    inst       = random_inst();
    ent        = '0;
    ent.vld    = 1'b1;
    st         = '0;
    st.trap    = use_trap;
    st.br_miss = ~use_trap;
    send_inst(inst);
    @(posedge clk);
    idu_inst                  <= random_inst();   // Decode keeps offering.
    reg_use[dpu_pkg::EXU_IDX] <= ent;
    exu                       <= st;
    wait_dpu_vld(1'b1, name);
    check_eq("unit_vld", 256'(unit_vld), 256'(0));
    check_eq("dpu_inst", 256'(dpu_inst), 256'(inst));
    @(posedge clk);
    idu_vld <= 1'b0;
    reg_use <= '0;
    exu     <= '0;
    @(negedge clk);
    check_eq("dpu_vld", 256'(dpu_vld), 256'(0));
    report_test(name, err0);
  endtask

  initial
  begin
    rst      <= 1'b1;
    idu_vld  <= 1'b0;
    idu_inst <= '0;
    regs     <= '0;
    reg_use  <= '0;
    exu      <= '0;
    reset_idle();
    steering_sweep();
    operand_targets();
    hazard_hold();
    execute_freeze();
    flush_slot(1'b0, "flush br_miss");
    flush_slot(1'b1, "flush trap");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/dpu_pkg.sv
hdl/dispatch_reg.sv
hdl/pipe_control.sv
hdl/operand_path.sv
hdl/unit_steer.sv
hdl/riscv_dpu.sv
sim/tb_riscv_dpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_riscv_dpu -o tb_riscv_dpu

./obj_dir/tb_riscv_dpu | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished cleanly"
